// File: mipsExecCore.f
+incdir+common
common/mipsPkg.sv
decoder/mainDecoder.sv
decoder/aluDecoder.sv
design/alu.sv
design/hiloUnit.sv
design/registerFile.sv
design/mipsExecCore.sv
verification/mipsExecCoreTb.sv

// File: runSim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

# Build the testbench with the core
verilator --binary --timing --assert -Wno-fatal \
    -f mipsExecCore.f --top-module mipsExecCoreTb -o simMipsExecCore

# Run, keep a log for the verdict
./obj_dir/simMipsExecCore | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
else
    exit 1
fi

// File: verification/mipsExecCoreTb.sv
`timescale 1ns/1ps
`include "mipsCore_defs.svh"

module mipsExecCoreTb;

    logic             clk;
    logic             reset;
    logic             instrValid;
    mipsPkg::wordT    instr;
    logic             wbValid;
    mipsPkg::regAddrT wbAddr;
    mipsPkg::wordT    wbData;

    // Stimulus and expected results per cycle
    mipsPkg::wordT    instrTab[$];
    logic             validTab[$];
    logic             expValid[$];
    mipsPkg::regAddrT expAddr[$];
    mipsPkg::wordT    expData[$];

    // Reference model state
    mipsPkg::wordT    refRegs[32];
    mipsPkg::wordT    refHi;
    mipsPkg::wordT    refLo;

    int errValid;
    int errAddr;
    int errData;
    int cycleCount;
    int cycleLimit;
    int seed;

    mipsExecCore dut_i (
        .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Abort once the cycle limit is passed
    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Instruction encoding
    ////////////////////////////////////////
    function automatic mipsPkg::wordT rType(input mipsPkg::functT fn,
        input mipsPkg::regAddrT rs, input mipsPkg::regAddrT rt,
        input mipsPkg::regAddrT rd, input mipsPkg::shamtT sa);
        return {`R_TYPE, rs, rt, rd, sa, fn};
    endfunction

    function automatic mipsPkg::wordT iType(input mipsPkg::opcodeT op,
        input mipsPkg::regAddrT rs, input mipsPkg::regAddrT rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    ////////////////////////////////////////
    // Reference model step for one instruction
    ////////////////////////////////////////
    task automatic addEntry(input mipsPkg::wordT w, input logic v);
        mipsPkg::wordT    a;
        mipsPkg::wordT    b;
        mipsPkg::wordT    sImm;
        mipsPkg::wordT    zImm;
        mipsPkg::wordT    res;
        mipsPkg::regAddrT dst;
        logic [63:0]      prod;
        logic             wr;
        a    = refRegs[w[25:21]];
        b    = refRegs[w[20:16]];
        sImm = {{16{w[15]}}, w[15:0]};
        zImm = {16'h0000, w[15:0]};
        res  = '0;
        wr   = 1'b1;
        dst  = w[15:11];
        case (w[31:26])
            `R_TYPE:
            begin
                case (w[5:0])
                    `ADD, `ADDU: res = a + b;
                    `SUB, `SUBU: res = a - b;
                    `AND:  res = a & b;
                    `OR:   res = a | b;
                    `XOR:  res = a ^ b;
                    `NOR:  res = ~(a | b);
                    `SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    `SLL:  res = b << w[10:6];
                    `SRL:  res = b >> w[10:6];
                    `SRA:  res = $signed(b) >>> w[10:6];
                    `MFHI: res = refHi;
                    `MFLO: res = refLo;
                    // HI/LO writers leave the registers alone
                    `MTHI, `MTLO, `MULT, `MULTU:
                    begin
                        wr = 1'b0;
                        if (w[5:0] == `MULT)
                            prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                        else
                            prod = {32'h0, a} * {32'h0, b};
                        if (v && w[5:0] == `MTHI)
                            refHi = a;
                        else if (v && w[5:0] == `MTLO)
                            refLo = a;
                        else if (v)
                            {refHi, refLo} = prod;
                    end
                    default: wr = 1'b0;
                endcase
            end
            `ADDI, `ADDIU: res = a + sImm;
            `ANDI:  res = a & zImm;
            `ORI:   res = a | zImm;
            `XORI:  res = a ^ zImm;
            `SLTI:  res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
            `SLTIU: res = (a < sImm) ? 32'd1 : 32'd0;
            `LUI:   res = {w[15:0], 16'h0000};
            default: wr = 1'b0;
        endcase
        // Immediates target rt
        if (w[31:26] != `R_TYPE)
            dst = w[20:16];
        if (v && wr && dst != '0)
            refRegs[dst] = res;
        instrTab.push_back(w);
        validTab.push_back(v);
        expValid.push_back(v && wr);
        expAddr.push_back(dst);
        expData.push_back(res);
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////
    task automatic buildTable();
        logic [31:0]      rnd;
        int               kind;
        mipsPkg::regAddrT rs;
        mipsPkg::regAddrT rt;
        mipsPkg::regAddrT rd;
        // Cleared state after reset
        addEntry(rType(`ADDU, 1, 2, 3, 0), 1'b1);
        for (int r = 1; r < 32; r++)
            addEntry(rType(`OR, 5'(r), 0, 5'(r), 0), 1'b1);
        // HI/LO cleared by reset
        addEntry(rType(`MFHI, 0, 0, 26, 0), 1'b1);
        addEntry(rType(`MFLO, 0, 0, 27, 0), 1'b1);
        // Immediate extension
        addEntry(iType(`ORI, 0, 1, 16'h8001), 1'b1);
        addEntry(iType(`ADDI, 1, 2, 16'hFFFB), 1'b1);
        addEntry(iType(`LUI, 0, 3, 16'h8765), 1'b1);
        addEntry(iType(`ORI, 3, 4, 16'h4321), 1'b1);
        addEntry(iType(`ANDI, 4, 5, 16'hF0F0), 1'b1);
        addEntry(iType(`XORI, 4, 6, 16'hFFFF), 1'b1);
        addEntry(iType(`SLTI, 4, 7, 16'h0001), 1'b1);
        addEntry(iType(`SLTIU, 4, 8, 16'h0001), 1'b1);
        addEntry(iType(`SLTIU, 1, 9, 16'hFFFF), 1'b1);
        // R-type ALU, shifts, back-to-back dependency
        addEntry(rType(`ADD, 1, 2, 10, 0), 1'b1);
        addEntry(rType(`SUB, 2, 1, 11, 0), 1'b1);
        addEntry(rType(`AND, 4, 6, 12, 0), 1'b1);
        addEntry(rType(`XOR, 4, 1, 13, 0), 1'b1);
        addEntry(rType(`NOR, 4, 2, 14, 0), 1'b1);
        addEntry(rType(`SLT, 4, 1, 12, 0), 1'b1);
        addEntry(rType(`SLTU, 4, 1, 13, 0), 1'b1);
        addEntry(rType(`SRL, 0, 4, 16, 7), 1'b1);
        addEntry(rType(`SRA, 0, 4, 17, 7), 1'b1);
        addEntry(rType(`SLL, 0, 4, 14, 4), 1'b1);
        addEntry(rType(`ADDU, 14, 1, 15, 0), 1'b1);
        addEntry(rType(`SUBU, 15, 14, 16, 0), 1'b1);
        // Products into HI/LO
        addEntry(rType(`MULT, 4, 1, 0, 0), 1'b1);
        addEntry(rType(`MFHI, 0, 0, 17, 0), 1'b1);
        addEntry(rType(`MFLO, 0, 0, 18, 0), 1'b1);
        addEntry(rType(`MULTU, 4, 1, 0, 0), 1'b1);
        addEntry(rType(`MFHI, 0, 0, 19, 0), 1'b1);
        addEntry(rType(`MFLO, 0, 0, 20, 0), 1'b1);
        // Moves to HI/LO
        addEntry(rType(`MTHI, 6, 0, 0, 0), 1'b1);
        addEntry(rType(`MTLO, 5, 0, 0, 0), 1'b1);
        addEntry(rType(`MFHI, 0, 0, 21, 0), 1'b1);
        addEntry(rType(`MFLO, 0, 0, 22, 0), 1'b1);
        // No-effect cases and a read-back of the old values
        addEntry(iType(6'b111111, 1, 1, 16'h1234), 1'b1);
        addEntry(rType(6'b001111, 1, 2, 1, 0), 1'b1);
        addEntry(iType(`ORI, 0, 0, 16'h1234), 1'b1);
        addEntry(iType(`ORI, 0, 1, 16'hBEEF), 1'b0);
        addEntry(rType(`MULT, 4, 4, 0, 0), 1'b0);
        addEntry(rType(`OR, 1, 0, 23, 0), 1'b1);
        addEntry(rType(`OR, 0, 0, 24, 0), 1'b1);
        addEntry(rType(`MFHI, 0, 0, 25, 0), 1'b1);
        // Random mix on r1..r7
        for (int n = 0; n < 40; n++)
        begin
            rnd  = $random(seed);
            kind = int'(rnd[31:29] % 6);
            rs   = 5'(rnd[27:24] % 7 + 1);
            rt   = 5'(rnd[23:20] % 7 + 1);
            rd   = 5'(rnd[19:16] % 7 + 1);
            case (kind)
                0: addEntry(iType(`ORI, rs, rt, rnd[15:0]), 1'b1);
                1: addEntry(iType(`ADDIU, rs, rt, rnd[15:0]), 1'b1);
                2: addEntry(rType(`ADD, rs, rt, rd, 0), 1'b1);
                3: addEntry(rType(`SUB, rs, rt, rd, 0), 1'b1);
                4: addEntry(rType(`SLT, rs, rt, rd, 0), 1'b1);
                default: addEntry(rType(`SLTU, rs, rt, rd, 0), 1'b1);
            endcase
        end
    endtask

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic checkValid(input logic got, input logic exp, input int idx);
        if (got !== exp)
        begin
            $display("FAILED entry %0d wbValid: got %h, expected %h", idx, got, exp);
            errValid++;
        end
    endtask

    task automatic checkAddr(input mipsPkg::regAddrT got, input mipsPkg::regAddrT exp,
        input int idx);
        if (got !== exp)
        begin
            $display("FAILED entry %0d wbAddr: got %h, expected %h", idx, got, exp);
            errAddr++;
        end
    endtask

    task automatic checkData(input mipsPkg::wordT got, input mipsPkg::wordT exp,
        input int idx);
        if (got !== exp)
        begin
            $display("FAILED entry %0d wbData: got %h, expected %h", idx, got, exp);
            errData++;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial
    begin
        seed       = 31;
        errValid   = 0;
        errAddr    = 0;
        errData    = 0;
        cycleCount = 0;
        refHi      = '0;
        refLo      = '0;
        for (int r = 0; r < 32; r++)
            refRegs[r] = '0;
        // ADDU presented while reset holds
        reset      = 1'b1;
        instrValid = 1'b1;
        instr      = rType(`ADDU, 1, 2, 3, 0);
        buildTable();
        // Reset cycles plus table plus 20
        cycleLimit = 4 + instrTab.size() + 20;
        repeat (3)
        begin
            @(negedge clk);
            #3;
            checkValid(wbValid, 1'b0, -1);
        end
        for (int i = 0; i < instrTab.size(); i++)
        begin
            @(negedge clk);
            reset      = 1'b0;
            instr      = instrTab[i];
            instrValid = validTab[i];
            // Just before the rising edge
            #3;
            checkValid(wbValid, expValid[i], i);
            if (expValid[i])
            begin
                checkAddr(wbAddr, expAddr[i], i);
                checkData(wbData, expData[i], i);
            end
        end
        @(negedge clk);
        instrValid = 1'b0;
        $display("Errors: wbValid %0d, wbAddr %0d, wbData %0d", errValid, errAddr, errData);
        if (errValid + errAddr + errData == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: design/mipsExecCore.sv
`timescale 1ns/1ps

module mipsExecCore (
    input  logic             clk,
    input  logic             reset,
    input  logic             instrValid,
    input  mipsPkg::wordT    instr,
    output logic             wbValid,
    output mipsPkg::regAddrT wbAddr,
    output mipsPkg::wordT    wbData
);

    // Decoder controls
    logic           regWrite;
    logic           regDst;
    logic           aluSrc;
    logic           retSrc;
    logic           hiloWrite;
    logic           hiloToReg;
    logic           hiloSrc;
    mipsPkg::aluOpT aluOp;

    // Datapath
    mipsPkg::wordT  rsData;
    mipsPkg::wordT  rtData;
    mipsPkg::wordT  aluResult;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////
    mainDecoder mainDecoder_i (
        .op(instr[31:26]), .funct(instr[5:0]),
        .regWrite(regWrite), .regDst(regDst), .aluSrc(aluSrc), .retSrc(retSrc),
        .hiloWrite(hiloWrite), .hiloToReg(hiloToReg), .hiloSrc(hiloSrc)
    );

    aluDecoder aluDecoder_i (.op(instr[31:26]), .funct(instr[5:0]), .aluOp(aluOp));

    ////////////////////////////////////////
    // Execute and write-back
    ////////////////////////////////////////
    registerFile registerFile_i (
        .clk(clk), .reset(reset), .instrValid(instrValid),
        .regWrite(regWrite), .regDst(regDst), .instr(instr), .wdata(wbData),
        .rsData(rsData), .rtData(rtData), .wbValid(wbValid), .wbAddr(wbAddr)
    );

    alu alu_i (
        .aluOp(aluOp), .aluSrc(aluSrc), .rsData(rsData), .rtData(rtData),
        .instr(instr), .aluResult(aluResult)
    );

    // HI/LO only changes for a valid instruction
    hiloUnit hiloUnit_i (
        .clk(clk), .reset(reset), .hiloWrite(hiloWrite && instrValid),
        .hiloToReg(hiloToReg), .hiloSrc(hiloSrc), .retSrc(retSrc), .aluOp(aluOp),
        .rsData(rsData), .rtData(rtData), .aluResult(aluResult), .wbData(wbData)
    );

endmodule

// File: design/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic             clk,
    input  logic             reset,
    input  logic             instrValid,
    input  logic             regWrite,
    input  logic             regDst,
    input  mipsPkg::wordT    instr,
    input  mipsPkg::wordT    wdata,
    output mipsPkg::wordT    rsData,
    output mipsPkg::wordT    rtData,
    output logic             wbValid,
    output mipsPkg::regAddrT wbAddr
);

    mipsPkg::wordT    regs [32];
    mipsPkg::regAddrT rs;
    mipsPkg::regAddrT rt;
    mipsPkg::regAddrT rd;

    // Register fields of the word
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    // Reads, r0 hardwired to zero
    assign rsData = (rs == '0) ? '0 : regs[rs];
    assign rtData = (rt == '0) ? '0 : regs[rt];

    // Write port, also the core's write-back outputs
    assign wbAddr  = regDst ? rd : rt;
    assign wbValid = instrValid && regWrite && !reset;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        // Writes to r0 are dropped
        else if (wbValid && (wbAddr != '0))
            regs[wbAddr] <= wdata;
    end

endmodule

// File: design/hiloUnit.sv
`timescale 1ns/1ps
`include "mipsCore_defs.svh"

module hiloUnit (
    input  logic           clk,
    input  logic           reset,
    input  logic           hiloWrite,
    input  logic           hiloToReg,
    input  logic           hiloSrc,
    input  logic           retSrc,
    input  mipsPkg::aluOpT aluOp,
    input  mipsPkg::wordT  rsData,
    input  mipsPkg::wordT  rtData,
    input  mipsPkg::wordT  aluResult,
    output mipsPkg::wordT  wbData
);

    mipsPkg::wordT      hi;
    mipsPkg::wordT      lo;
    logic signed [63:0] prodSigned;
    logic [63:0]        prodUnsigned;
    logic [63:0]        product;

    ////////////////////////////////////////
    // Multiplier
    ////////////////////////////////////////
    assign prodSigned   = $signed(rsData) * $signed(rtData);
    assign prodUnsigned = rsData * rtData;
    assign product      = (aluOp == `ALU_MULTU) ? prodUnsigned : prodSigned;

    // HI/LO pair, updated on the edge after the instruction
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hi <= '0;
            lo <= '0;
        end
        else if (hiloWrite)
        begin
            if (hiloSrc)
            begin
                // MTHI / MTLO, one half from rs
                if (hiloToReg)
                    hi <= rsData;
                else
                    lo <= rsData;
            end
            else
            begin
                hi <= product[63:32];
                lo <= product[31:0];
            end
        end
    end

    // Write-back result, HI/LO for MFHI/MFLO
    assign wbData = retSrc ? (hiloToReg ? hi : lo) : aluResult;

    // Product loads only come from a multiply decode
    assert property (@(posedge clk) disable iff (reset)
        (hiloWrite && !hiloSrc) |-> (aluOp == `ALU_MULT || aluOp == `ALU_MULTU))
        else $error("hiloUnit: product write without multiply aluOp");

endmodule

// File: design/alu.sv
`timescale 1ns/1ps
`include "mipsCore_defs.svh"

module alu (
    input  mipsPkg::aluOpT aluOp,
    input  logic           aluSrc,
    input  mipsPkg::wordT  rsData,
    input  mipsPkg::wordT  rtData,
    input  mipsPkg::wordT  instr,
    output mipsPkg::wordT  aluResult
);

    mipsPkg::opcodeT op;
    mipsPkg::shamtT  shamt;
    logic [15:0]     imm;
    logic            zeroExt;
    mipsPkg::wordT   immExt;
    mipsPkg::wordT   srcB;

    // Instruction fields
    assign op    = instr[31:26];
    assign shamt = instr[10:6];
    assign imm   = instr[15:0];

    ////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////

    // Logical immediates zero-extend, the rest sign-extend
    assign zeroExt = (op == `ANDI) || (op == `ORI) || (op == `XORI);
    assign immExt  = zeroExt ? {16'b0, imm} : {{16{imm[15]}}, imm};
    assign srcB    = aluSrc ? immExt : rtData;

    ////////////////////////////////////////
    // Integer operations
    ////////////////////////////////////////
    always_comb
    begin
        case (aluOp)
            `ALU_ADD:  aluResult = rsData + srcB;
            `ALU_SUB:  aluResult = rsData - srcB;
            `ALU_AND:  aluResult = rsData & srcB;
            `ALU_OR:   aluResult = rsData | srcB;
            `ALU_XOR:  aluResult = rsData ^ srcB;
            `ALU_NOR:  aluResult = ~(rsData | srcB);
            // Set-less-than as 0 or 1
            `ALU_SLT:  aluResult = {31'b0, $signed(rsData) < $signed(srcB)};
            `ALU_SLTU: aluResult = {31'b0, rsData < srcB};
            // Shifts act on rt, never on the immediate
            `ALU_SLL:  aluResult = rtData << shamt;
            `ALU_SRL:  aluResult = rtData >> shamt;
            `ALU_SRA:  aluResult = $signed(rtData) >>> shamt;
            // Low half of the immediate into the upper half
            `ALU_LUI:  aluResult = {srcB[15:0], 16'b0};
            // Multiply codes, handled in the HI/LO unit
            default:   aluResult = '0;
        endcase
    end

endmodule

// File: decoder/aluDecoder.sv
`timescale 1ns/1ps
`include "mipsCore_defs.svh"

module aluDecoder (
    input  mipsPkg::opcodeT op,
    input  mipsPkg::functT  funct,
    output mipsPkg::aluOpT  aluOp
);

    ////////////////////////////////////////
    // Opcode / funct to ALU code
    ////////////////////////////////////////
    always_comb
    begin
        case (op)
            `R_TYPE:
            begin
                case (funct)
                    // No overflow trap, signed and unsigned add alike
                    `ADD, `ADDU: aluOp = `ALU_ADD;
                    `SUB, `SUBU: aluOp = `ALU_SUB;
                    `AND:        aluOp = `ALU_AND;
                    `OR:         aluOp = `ALU_OR;
                    `XOR:        aluOp = `ALU_XOR;
                    `NOR:        aluOp = `ALU_NOR;
                    `SLT:        aluOp = `ALU_SLT;
                    `SLTU:       aluOp = `ALU_SLTU;
                    // Shifts by shamt
                    `SLL:        aluOp = `ALU_SLL;
                    `SRL:        aluOp = `ALU_SRL;
                    `SRA:        aluOp = `ALU_SRA;
                    // Product signedness for the HI/LO unit
                    `MULT:       aluOp = `ALU_MULT;
                    `MULTU:      aluOp = `ALU_MULTU;
                    // HI/LO moves and unknowns, result unused
                    default:     aluOp = `ALU_ADD;
                endcase
            end
            `ADDI, `ADDIU: aluOp = `ALU_ADD;
            `ANDI:         aluOp = `ALU_AND;
            `ORI:          aluOp = `ALU_OR;
            `XORI:         aluOp = `ALU_XOR;
            `SLTI:         aluOp = `ALU_SLT;
            `SLTIU:        aluOp = `ALU_SLTU;
            `LUI:          aluOp = `ALU_LUI;
            // Nothing gets written for these
            default:       aluOp = `ALU_ADD;
        endcase
    end

endmodule

// File: decoder/mainDecoder.sv
`timescale 1ns/1ps
`include "mipsCore_defs.svh"

module mainDecoder (
    input  mipsPkg::opcodeT op,
    input  mipsPkg::functT  funct,
    output logic            regWrite,
    output logic            regDst,
    output logic            aluSrc,
    output logic            retSrc,
    output logic            hiloWrite,
    output logic            hiloToReg,
    output logic            hiloSrc
);

    // Packed control word in unpack order
    logic [6:0] controls;

    // regWrite  write the register file
    // regDst    destination 0 -> rt, 1 -> rd
    // aluSrc    second operand 0 -> rt, 1 -> immediate
    // retSrc    result 0 -> ALU, 1 -> HI/LO
    // hiloWrite write HI and/or LO
    // hiloToReg HI/LO select 0 -> LO, 1 -> HI
    // hiloSrc   HI/LO source 0 -> product, 1 -> rs move
    assign {regWrite, regDst, aluSrc, retSrc,
            hiloWrite, hiloToReg, hiloSrc} = controls;

    always_comb
    begin
        case (op)
            `R_TYPE:
            begin
                case (funct)
                    // Reads of HI/LO into rd
                    `MFHI: controls = 7'b1101_010;
                    `MFLO: controls = 7'b1101_000;
                    // Moves from rs into HI/LO
                    `MTHI: controls = 7'b0000_111;
                    `MTLO: controls = 7'b0000_101;
                    // Product goes to both halves
                    `MULT, `MULTU: controls = 7'b0000_100;
                    // Plain ALU ops into rd
                    `ADD, `ADDU, `SUB, `SUBU,
                    `AND, `OR, `XOR, `NOR,
                    `SLT, `SLTU,
                    `SLL, `SRL, `SRA: controls = 7'b1100_000;
                    // Unknown funct has no side effect
                    default: controls = 7'b0000_000;
                endcase
            end
            // Immediates write rt from the ALU
            `ADDI, `ADDIU, `ANDI, `ORI, `XORI,
            `SLTI, `SLTIU, `LUI: controls = 7'b1010_000;
            // Unknown opcode
            default: controls = 7'b0000_000;
        endcase
    end

endmodule

// File: common/mipsPkg.sv
package mipsPkg;

    ////////////////////////////////////////
    // Instruction set field types
    ////////////////////////////////////////

    // Data word, also the raw instruction word
    typedef logic [31:0] wordT;

    // Register number, rs / rt / rd fields
    typedef logic [4:0] regAddrT;

    // Primary opcode, instr[31:26]
    typedef logic [5:0] opcodeT;

    // R-type function field, instr[5:0]
    typedef logic [5:0] functT;

    // Shift amount, instr[10:6]
    typedef logic [4:0] shamtT;

    ////////////////////////////////////////
    // Internal control types
    ////////////////////////////////////////

    // ALU operation select
    // Values come from the ALU_* macros
    typedef logic [3:0] aluOpT;

endpackage

// File: common/mipsCore_defs.svh
`ifndef MIPSCORE_DEFS_SVH
`define MIPSCORE_DEFS_SVH

////////////////////////////////////////
// Primary opcodes
////////////////////////////////////////
`define R_TYPE 6'b000000
`define ADDI   6'b001000
`define ADDIU  6'b001001
`define SLTI   6'b001010
`define SLTIU  6'b001011
`define ANDI   6'b001100
`define ORI    6'b001101
`define XORI   6'b001110
`define LUI    6'b001111

////////////////////////////////////////
// R-type funct codes
////////////////////////////////////////
`define SLL    6'b000000
`define SRL    6'b000010
`define SRA    6'b000011
`define MFHI   6'b010000
`define MTHI   6'b010001
`define MFLO   6'b010010
`define MTLO   6'b010011
`define MULT   6'b011000
`define MULTU  6'b011001
`define ADD    6'b100000
`define ADDU   6'b100001
`define SUB    6'b100010
`define SUBU   6'b100011
`define AND    6'b100100
`define OR     6'b100101
`define XOR    6'b100110
`define NOR    6'b100111
`define SLT    6'b101010
`define SLTU   6'b101011

////////////////////////////////////////
// ALU operation codes
////////////////////////////////////////
`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_AND   4'd2
`define ALU_OR    4'd3
`define ALU_XOR   4'd4
`define ALU_NOR   4'd5
`define ALU_SLT   4'd6
`define ALU_SLTU  4'd7
`define ALU_SLL   4'd8
`define ALU_SRL   4'd9
`define ALU_SRA   4'd10
`define ALU_LUI   4'd11
// Multiply codes only steer the HI/LO unit
`define ALU_MULT  4'd12
`define ALU_MULTU 4'd13

`endif
